// ==== sources.f ====
hw/biu_pkg.sv
hw/address_unit.sv
hw/bus_timing.sv
hw/bus_pins.sv
hw/ika87ad_biu.sv
testbench/tb_ika87ad_biu.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the BIU testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
    --top-module tb_ika87ad_biu \
    -f sources.f \
    -o tb_ika87ad_biu

# Run status is folded into the log search below
./obj_dir/tb_ika87ad_biu > "$LOG" 2>&1 || true
cat "$LOG"

if grep -qx "Result: PASSED" "$LOG"; then
    echo "Simulation passed"
else
    echo "Simulation failed, see $LOG"
    exit 1
fi

// ==== testbench/tb_ika87ad_biu.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_ika87ad_biu;

    import biu_pkg::*;

    localparam logic [15:0] TB_RESET_PC = 16'h1F00;
    localparam int N_CMD    = 16;
    localparam int WAIT_MAX = 400;      // Emuclk cycles per handshake wait

    logic       emuclk;
    logic       mrst_n;
    logic       i_mcuclk_pcen;
    logic       i_cmd_valid;
    bus_cmd_t   i_cmd;
    logic       o_cmd_ready;
    logic       o_ale;
    logic       o_rd_n;
    logic       o_wr_n;
    logic [7:0] i_pc_i;
    logic [7:0] o_pc_o;
    logic [7:0] o_pc_dir;
    wire  [7:0] i_pd_i;
    logic [7:0] o_pd_o;
    logic [7:0] o_pd_dir;
    logic       o_rsp_valid;
    bus_rsp_t   o_rsp;
    logic       i_rsp_ready;

    bus_cmd_t    cmd_tab  [N_CMD];
    logic [15:0] exp_addr [N_CMD];
    logic [7:0]  exp_data [N_CMD];
    logic [7:0]  written  [logic [15:0]];   // Bytes the table writes

    logic [7:0]  mem [0:65535];             // External memory
    logic [15:0] lat_addr;                  // Address latch, ALE fall
    logic [7:0]  pd_hold;                   // Port D bus hold
    logic        rand_on;
    logic        cmd_xfer;                  // Handshakes seen on the last posedge
    logic        rsp_xfer;
    bus_rsp_t    rsp_seen;
    int          strobe_idx;                // Bus cycles checked so far
    int          ale_cnt;
    int          rd_len;
    int          wr_len;
    logic        ale_prev;
    logic        rd_prev;
    logic        wr_prev;

    ika87ad_biu #(.RESET_PC(TB_RESET_PC)) u_dut (
        .emuclk       (emuclk),
        .mrst_n       (mrst_n),
        .i_mcuclk_pcen(i_mcuclk_pcen),
        .i_cmd_valid  (i_cmd_valid),
        .i_cmd        (i_cmd),
        .o_cmd_ready  (o_cmd_ready),
        .o_ale        (o_ale),
        .o_rd_n       (o_rd_n),
        .o_wr_n       (o_wr_n),
        .i_pc_i       (i_pc_i),
        .o_pc_o       (o_pc_o),
        .o_pc_dir     (o_pc_dir),
        .i_pd_i       (i_pd_i),
        .o_pd_o       (o_pd_o),
        .o_pd_dir     (o_pd_dir),
        .o_rsp_valid  (o_rsp_valid),
        .o_rsp        (o_rsp),
        .i_rsp_ready  (i_rsp_ready)
    );

    initial emuclk = 1'b0;
    always #20 emuclk = ~emuclk;            // 40 ns period

    //////////////////////////////
    // Reporting
    //////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Result: FAILED");
        $fatal(1);
    endtask

    task automatic value_mismatch(input string what, input logic [15:0] got,
                                  input logic [15:0] exp);
        abort_run($sformatf("FAILED %s got 0x%0h expected 0x%0h", what, got, exp));
    endtask

    //////////////////////////////
    // Command table, expected results
    //////////////////////////////

    function automatic bus_cmd_t mk_cmd(input bus_acc_e kind, input logic load_pc,
                                        input logic [15:0] addr, input logic [7:0] wdata);
        bus_cmd_t c;
        c.kind    = kind;
        c.load_pc = load_pc;
        c.addr    = addr;
        c.wdata   = wdata;
        return c;
    endfunction

    task automatic fill_table();
        cmd_tab[0]  = mk_cmd(RD4, 1'b0, 16'h0000, 8'h00);    // 1F00
        cmd_tab[1]  = mk_cmd(RD4, 1'b0, 16'h0000, 8'h00);    // 1F01
        cmd_tab[2]  = mk_cmd(RD4, 1'b0, 16'h0000, 8'h00);    // 1F02
        cmd_tab[3]  = mk_cmd(RD4, 1'b1, 16'h30FF, 8'h00);    // Jump
        cmd_tab[4]  = mk_cmd(RD4, 1'b0, 16'h0000, 8'h00);    // 3100
        cmd_tab[5]  = mk_cmd(WR3, 1'b0, 16'h4005, 8'h3C);
        cmd_tab[6]  = mk_cmd(RD3, 1'b0, 16'h4005, 8'h00);    // Reads back 3C
        cmd_tab[7]  = mk_cmd(RD3, 1'b0, 16'h1234, 8'h00);    // Preset byte
        cmd_tab[8]  = mk_cmd(WR3, 1'b0, 16'h1234, 8'h5A);
        cmd_tab[9]  = mk_cmd(RD4, 1'b1, 16'hFFFF, 8'h00);    // PC wraps after this
        cmd_tab[10] = mk_cmd(RD4, 1'b0, 16'h0000, 8'h00);    // 0000
        cmd_tab[11] = mk_cmd(RD3, 1'b0, 16'h1234, 8'h00);
        cmd_tab[12] = mk_cmd(WR3, 1'b0, 16'h0000, 8'hC3);
        cmd_tab[13] = mk_cmd(RD4, 1'b0, 16'h0000, 8'h00);    // 0001
        cmd_tab[14] = mk_cmd(RD3, 1'b0, 16'h0000, 8'h00);
        cmd_tab[15] = mk_cmd(WR3, 1'b0, 16'h30FF, 8'h77);
    endtask

    // Preset pattern unless the table wrote the byte earlier
    function automatic logic [7:0] model_byte(input logic [15:0] a);
        if (written.exists(a)) begin
            return written[a];
        end
        return a[7:0] ^ 8'hA5;
    endfunction

    task automatic build_expected();
        logic [15:0] pc;
        logic [15:0] a;
        pc = TB_RESET_PC;
        for (int i = 0; i < N_CMD; i++) begin
            case (cmd_tab[i].kind)
                RD4: begin
                    a           = cmd_tab[i].load_pc ? cmd_tab[i].addr : pc;
                    pc          = a + 16'd1;            // Wraps at the top
                    exp_data[i] = model_byte(a);
                end
                WR3: begin
                    a           = cmd_tab[i].addr;
                    written[a]  = cmd_tab[i].wdata;
                    exp_data[i] = cmd_tab[i].wdata;      // Echo of the written byte
                end
                default: begin
                    a           = cmd_tab[i].addr;
                    exp_data[i] = model_byte(a);
                end
            endcase
            exp_addr[i] = a;
        end
    endtask

    //////////////////////////////
    // Memory model
    //////////////////////////////

    assign i_pd_i = pd_hold;

    initial begin : memory_model
        logic ale_d;
        logic rd_d;
        logic wr_d;
        for (int a = 0; a < 65536; a++) begin
            mem[a] = a[7:0] ^ 8'hA5;
        end
        pd_hold = 8'h00;
        ale_d   = 1'b0;
        rd_d    = 1'b1;
        wr_d    = 1'b1;
        forever begin
            @(o_ale or o_rd_n or o_wr_n);
            if (mrst_n) begin
                if (ale_d && !o_ale) lat_addr = {o_pc_o, o_pd_o};   // ALE fall
                if (rd_d && !o_rd_n) pd_hold = mem[lat_addr];       // Held past /RD rise
                if (!wr_d && o_wr_n) mem[lat_addr] = o_pd_o;        // /WR rise
            end
            ale_d = o_ale;
            rd_d  = o_rd_n;
            wr_d  = o_wr_n;
        end
    end

    //////////////////////////////
    // Stimulus and sampling
    //////////////////////////////

    // pcen high about 3 in 4, response stalls about 1 in 3
    initial begin : random_drive
        void'($urandom(17));
        i_mcuclk_pcen = 1'b1;
        i_rsp_ready   = 1'b1;
        forever begin
            @(negedge emuclk);
            if (rand_on) begin
                i_mcuclk_pcen = ($urandom % 4) != 0;
                i_rsp_ready   = ($urandom % 3) != 0;
            end
        end
    end

    always @(posedge emuclk) begin
        rand_on  <= mrst_n;
        cmd_xfer <= i_cmd_valid && o_cmd_ready;
        rsp_xfer <= o_rsp_valid && i_rsp_ready;
        rsp_seen <= o_rsp;
    end

    //////////////////////////////
    // Strobe monitor
    //////////////////////////////

    task automatic check_strobe(input logic is_wr, input int len);
        bus_acc_e kind;
        int       exp_len;
        assert (strobe_idx < N_CMD) else abort_run("Bus cycle seen past the end of the table");
        kind    = cmd_tab[strobe_idx].kind;
        exp_len = (kind == RD4) ? 6 : 4;
        assert (is_wr == (kind == WR3))
            else abort_run($sformatf("Cycle %0d used the wrong strobe", strobe_idx));
        assert (len == exp_len)
            else abort_run($sformatf("Cycle %0d strobe lasted %0d enabled phases, not %0d",
                                     strobe_idx, len, exp_len));
        assert (lat_addr == exp_addr[strobe_idx])
            else value_mismatch($sformatf("bus address[%0d]", strobe_idx), lat_addr,
                                exp_addr[strobe_idx]);
        strobe_idx++;
    endtask

    // Pre-edge values, one emuclk behind the pins
    always @(posedge emuclk) begin
        if (!mrst_n) begin
            strobe_idx = 0;
            ale_cnt    = 0;
            rd_len     = 0;
            wr_len     = 0;
            ale_prev   = 1'b0;
            rd_prev    = 1'b1;
            wr_prev    = 1'b1;
        end else begin
            assert (o_rd_n || o_wr_n) else abort_run("/RD and /WR were low together");
            // Port C drives all cycle, port D drives the address and write data
            if (o_ale || !o_rd_n || !o_wr_n) begin
                assert (o_pc_dir == 8'hFF)
                    else value_mismatch("o_pc_dir", 16'(o_pc_dir), 16'hFF);
            end
            if (o_ale || !o_wr_n) begin
                assert (o_pd_dir == 8'hFF)
                    else value_mismatch("o_pd_dir", 16'(o_pd_dir), 16'hFF);
            end
            if (o_ale && !ale_prev) ale_cnt++;
            if ((!o_rd_n && rd_prev) || (!o_wr_n && wr_prev)) begin
                assert (ale_cnt == 1)
                    else abort_run($sformatf("%0d ALE pulses before strobe", ale_cnt));
                ale_cnt = 0;
            end
            if (i_mcuclk_pcen && !o_rd_n) rd_len++;
            if (i_mcuclk_pcen && !o_wr_n) wr_len++;
            if (o_rd_n && !rd_prev) begin
                check_strobe(1'b0, rd_len);
                rd_len = 0;
            end
            if (o_wr_n && !wr_prev) begin
                check_strobe(1'b1, wr_len);
                wr_len = 0;
            end
            ale_prev = o_ale;
            rd_prev  = o_rd_n;
            wr_prev  = o_wr_n;
        end
    end

    //////////////////////////////
    // Command and response streams
    //////////////////////////////

    task automatic check_reset_state();
        assert (o_ale == 1'b0) else value_mismatch("o_ale", 16'(o_ale), 16'h0);
        assert (o_rd_n == 1'b1) else value_mismatch("o_rd_n", 16'(o_rd_n), 16'h1);
        assert (o_wr_n == 1'b1) else value_mismatch("o_wr_n", 16'(o_wr_n), 16'h1);
        assert (o_rsp_valid == 1'b0) else value_mismatch("o_rsp_valid", 16'(o_rsp_valid), 16'h0);
        assert (o_cmd_ready == 1'b1) else value_mismatch("o_cmd_ready", 16'(o_cmd_ready), 16'h1);
        assert (o_pc_dir == 8'h00) else value_mismatch("o_pc_dir", 16'(o_pc_dir), 16'h0);
        assert (o_pd_dir == 8'h00) else value_mismatch("o_pd_dir", 16'(o_pd_dir), 16'h0);
    endtask

    task automatic send_commands();
        int wait_cnt;
        for (int i = 0; i < N_CMD; i++) begin
            i_cmd_valid = 1'b1;
            i_cmd       = cmd_tab[i];
            wait_cnt    = 0;
            @(negedge emuclk);
            while (!cmd_xfer) begin
                wait_cnt++;
                assert (wait_cnt < WAIT_MAX)
                    else abort_run($sformatf("Command %0d was never accepted", i));
                @(negedge emuclk);
            end
        end
        i_cmd_valid = 1'b0;
        i_cmd       = '0;
    endtask

    task automatic check_response(input int j);
        assert (rsp_seen.kind == cmd_tab[j].kind)
            else value_mismatch($sformatf("o_rsp.kind[%0d]", j), 16'(rsp_seen.kind),
                                16'(cmd_tab[j].kind));
        assert (rsp_seen.addr == exp_addr[j])
            else value_mismatch($sformatf("o_rsp.addr[%0d]", j), rsp_seen.addr, exp_addr[j]);
        assert (rsp_seen.data == exp_data[j])
            else value_mismatch($sformatf("o_rsp.data[%0d]", j), 16'(rsp_seen.data),
                                16'(exp_data[j]));
        if (cmd_tab[j].kind == WR3) begin
            assert (mem[exp_addr[j]] == exp_data[j])
                else value_mismatch($sformatf("mem[%0h]", exp_addr[j]),
                                    16'(mem[exp_addr[j]]), 16'(exp_data[j]));
        end
    endtask

    task automatic collect_responses();
        int wait_cnt;
        for (int j = 0; j < N_CMD; j++) begin
            wait_cnt = 0;
            @(negedge emuclk);
            while (!rsp_xfer) begin
                wait_cnt++;
                assert (wait_cnt < WAIT_MAX)
                    else abort_run($sformatf("Response %0d never arrived", j));
                @(negedge emuclk);
            end
            check_response(j);
        end
    endtask

    //////////////////////////////
    // Main sequence
    //////////////////////////////

    initial begin : main
        mrst_n      = 1'b0;
        i_cmd_valid = 1'b0;
        i_cmd       = '0;
        i_pc_i      = 8'h00;
        fill_table();
        build_expected();
        repeat (8) @(posedge emuclk);
        @(negedge emuclk);
        mrst_n = 1'b1;
        @(negedge emuclk);
        check_reset_state();
        fork
            send_commands();
            collect_responses();
        join
        repeat (40) begin                       // Nothing extra may come out
            @(negedge emuclk);
            assert (!rsp_xfer) else abort_run("A response arrived after the last command");
        end
        if (strobe_idx == N_CMD) begin
            $display("Result: PASSED");
            $finish;
        end else begin
            abort_run($sformatf("Saw %0d bus cycles for %0d commands", strobe_idx, N_CMD));
        end
    end

    initial begin : watchdog
        int cycles;
        cycles = 0;
        while (cycles < 20000) begin
            @(posedge emuclk);
            cycles++;
        end
        abort_run("Simulation ran past its cycle limit");
    end

endmodule

`default_nettype wire

// ==== hw/ika87ad_biu.sv ====
`timescale 1ns/1ns
`default_nettype none

module ika87ad_biu #(
    parameter logic [15:0] RESET_PC = 16'h0000
) (
    input  wire               emuclk,
    input  wire               mrst_n,
    input  wire               i_mcuclk_pcen,

    input  wire               i_cmd_valid,
    input  wire biu_pkg::bus_cmd_t i_cmd,
    output logic              o_cmd_ready,

    output logic              o_ale,
    output logic              o_rd_n,
    output logic              o_wr_n,

    input  wire  [7:0]        i_pc_i,   // Port C is address only here
    output logic [7:0]        o_pc_o,
    output logic [7:0]        o_pc_dir,

    input  wire  [7:0]        i_pd_i,
    output logic [7:0]        o_pd_o,
    output logic [7:0]        o_pd_dir,

    output logic              o_rsp_valid,
    output biu_pkg::bus_rsp_t o_rsp,
    input  wire               i_rsp_ready
);

    import biu_pkg::*;

    logic     req_valid;
    bus_req_t req;
    logic     req_ready;
    phase_t   phase;
    logic     cyc_start;
    bus_req_t cyc_req;
    logic     rsp_room;

    address_unit #(.RESET_PC(RESET_PC)) u_address_unit (
        .emuclk     (emuclk),       .mrst_n     (mrst_n),
        .i_cmd_valid(i_cmd_valid),  .i_cmd      (i_cmd),      .o_cmd_ready(o_cmd_ready),
        .o_req_valid(req_valid),    .o_req      (req),        .i_req_ready(req_ready)
    );

    bus_timing u_bus_timing (
        .emuclk     (emuclk),       .mrst_n     (mrst_n),     .i_mcuclk_pcen(i_mcuclk_pcen),
        .i_req_valid(req_valid),    .i_req      (req),        .o_req_ready(req_ready),
        .i_rsp_room (rsp_room),
        .o_phase    (phase),        .o_cyc_start(cyc_start),  .o_cyc_req  (cyc_req)
    );

    bus_pins u_bus_pins (
        .emuclk     (emuclk),       .mrst_n     (mrst_n),     .i_mcuclk_pcen(i_mcuclk_pcen),
        .i_phase    (phase),        .i_cyc_start(cyc_start),  .i_cyc_req  (cyc_req),
        .o_rsp_room (rsp_room),
        .o_ale      (o_ale),        .o_rd_n     (o_rd_n),     .o_wr_n     (o_wr_n),
        .o_pc_o     (o_pc_o),       .o_pc_dir   (o_pc_dir),
        .i_pd_i     (i_pd_i),       .o_pd_o     (o_pd_o),     .o_pd_dir   (o_pd_dir),
        .o_rsp_valid(o_rsp_valid),  .o_rsp      (o_rsp),      .i_rsp_ready(i_rsp_ready)
    );

endmodule

`default_nettype wire

// ==== hw/bus_pins.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_pins (
    input  wire               emuclk,
    input  wire               mrst_n,
    input  wire               i_mcuclk_pcen,

    // From the timing generator
    input  wire biu_pkg::phase_t   i_phase,
    input  wire               i_cyc_start,
    input  wire biu_pkg::bus_req_t i_cyc_req,
    output logic              o_rsp_room,

    // Strobes
    output logic              o_ale,
    output logic              o_rd_n,
    output logic              o_wr_n,

    // Port C address high, port D muxed address low / data
    output logic [7:0]        o_pc_o,
    output logic [7:0]        o_pc_dir,
    input  wire  [7:0]        i_pd_i,
    output logic [7:0]        o_pd_o,
    output logic [7:0]        o_pd_dir,

    // Response out
    output logic              o_rsp_valid,
    output biu_pkg::bus_rsp_t o_rsp,
    input  wire               i_rsp_ready
);

    import biu_pkg::*;

    logic [PH_W-1:0] ph_nx;     // Phase entered on the next advance
    logic            adv;       // Enabled edge inside a cycle
    logic            in_cyc;
    logic            is_rd;
    logic            is_wr;
    logic            strobe_on;
    logic            strobe_off;
    logic            cyc_end;
    logic            sample;
    logic            sample_q;  // Response load, one emuclk after sampling
    logic            ale_q;
    logic            rd_q;      // Active high inside
    logic            wr_q;
    logic            data_sel_q;    // Port D shows data, not address
    logic [7:0]      inlatch_q;
    logic            rsp_valid_q;
    bus_rsp_t        rsp_q;

    assign ph_nx  = {i_phase.ph[PH_W-2:0], 1'b0};
    assign in_cyc = i_phase.cur != IDLE;
    assign adv    = i_mcuclk_pcen && in_cyc;
    assign is_rd  = (i_phase.cur == RD4) || (i_phase.cur == RD3);
    assign is_wr  = i_phase.cur == WR3;

    assign strobe_on  = adv && ph_nx[PH_STROBE_ON];
    assign strobe_off = adv && ((i_phase.cur == RD4) ? ph_nx[RD4_STROBE_END]
                                                     : ph_nx[SHORT_STROBE_END]);
    assign cyc_end    = adv && ((i_phase.cur == RD4) ? i_phase.ph[PH_RD4_END]
                                                     : i_phase.ph[PH_RD3_END]);
    assign sample     = adv && i_phase.ph[PH_SAMPLE];

    //////////////////////////////
    // ALE, /RD, /WR
    //////////////////////////////

    always_ff @(posedge emuclk) begin
        if (!mrst_n) begin
            ale_q      <= 1'b0;
            rd_q       <= 1'b0;
            wr_q       <= 1'b0;
            data_sel_q <= 1'b0;
        end else begin
            if (i_cyc_start) begin
                ale_q <= 1'b1;                  // Phase 0 only
            end else if (adv && ph_nx[PH_ALE_OFF]) begin
                ale_q <= 1'b0;
            end

            if (strobe_on) begin
                rd_q <= is_rd;
                wr_q <= is_wr;
            end else if (strobe_off) begin
                rd_q <= 1'b0;
                wr_q <= 1'b0;
            end

            if (cyc_end) begin
                data_sel_q <= 1'b0;             // Next cycle opens with address
            end else if (strobe_on) begin
                data_sel_q <= 1'b1;
            end
        end
    end

    assign o_ale  = ale_q;
    assign o_rd_n = ~rd_q;
    assign o_wr_n = ~wr_q;

    //////////////////////////////
    // Address / data ports
    //////////////////////////////

    assign o_pc_o   = i_cyc_req.addr[15:8];
    assign o_pc_dir = {8{in_cyc}};
    assign o_pd_o   = data_sel_q ? i_cyc_req.wdata : i_cyc_req.addr[7:0];
    // Port D turns around for reads once the address phase is over
    assign o_pd_dir = {8{in_cyc && (!data_sel_q || is_wr)}};

    //////////////////////////////
    // Input latch and response
    //////////////////////////////

    always_ff @(posedge emuclk) begin
        if (sample && is_rd) begin
            inlatch_q <= i_pd_i;
        end
    end

    always_ff @(posedge emuclk) begin
        if (!mrst_n) begin
            sample_q    <= 1'b0;
            rsp_valid_q <= 1'b0;
        end else begin
            sample_q <= sample;
            if (sample_q) begin
                rsp_valid_q <= 1'b1;
            end else if (i_rsp_ready) begin
                rsp_valid_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge emuclk) begin
        if (sample_q) begin
            rsp_q.kind <= i_cyc_req.kind;
            rsp_q.addr <= i_cyc_req.addr;
            rsp_q.data <= (i_cyc_req.kind == WR3) ? i_cyc_req.wdata : inlatch_q;
        end
    end

    assign o_rsp_room  = !rsp_valid_q;
    assign o_rsp_valid = rsp_valid_q;
    assign o_rsp       = rsp_q;

    // Never both strobes on the bus
    a_no_rd_wr_overlap: assert property (@(posedge emuclk) disable iff (!mrst_n)
        !(!o_rd_n && !o_wr_n));

    // Cycle start is gated on room, so a held response is never overwritten
    a_rsp_no_overwrite: assert property (@(posedge emuclk) disable iff (!mrst_n)
        sample_q |-> !rsp_valid_q);

endmodule

`default_nettype wire

// ==== hw/bus_timing.sv ====
`timescale 1ns/1ns
`default_nettype none

module bus_timing (
    input  wire               emuclk,
    input  wire               mrst_n,
    input  wire               i_mcuclk_pcen,    // One phase per enabled edge

    // Request in
    input  wire               i_req_valid,
    input  wire biu_pkg::bus_req_t i_req,
    output logic              o_req_ready,

    // Response slot free in bus_pins
    input  wire               i_rsp_room,

    // Cycle state out to the pin side
    output biu_pkg::phase_t   o_phase,
    output logic              o_cyc_start,
    output biu_pkg::bus_req_t o_cyc_req
);

    import biu_pkg::*;

    phase_t   phase_q;
    bus_req_t cyc_req_q;        // Held for the whole cycle
    logic     last_ph;          // Final phase of the running cycle
    logic     at_boundary;
    logic     start;

    //////////////////////////////
    // Cycle boundary
    //////////////////////////////

    // RD4 folds at bit 11, three-state cycles at bit 8
    assign last_ph = (phase_q.cur == RD4) ? phase_q.ph[PH_RD4_END]
                                          : phase_q.ph[PH_RD3_END];

    // Idle counts as a boundary every enabled edge
    assign at_boundary = (phase_q.cur == IDLE) || last_ph;

    // Never start unless the response has somewhere to go
    assign o_req_ready = i_mcuclk_pcen && at_boundary && i_rsp_room;
    assign start       = o_req_ready && i_req_valid;

    assign o_cyc_start = start;
    assign o_phase     = phase_q;
    assign o_cyc_req   = cyc_req_q;

    //////////////////////////////
    // Phase sequencer
    //////////////////////////////

    always_ff @(posedge emuclk) begin
        if (!mrst_n) begin
            phase_q.ph  <= PH_W'(1);
            phase_q.cur <= IDLE;
        end else if (i_mcuclk_pcen) begin
            if (at_boundary) begin
                phase_q.ph  <= PH_W'(1);                    // Back to phase 0
                phase_q.cur <= start ? i_req.kind : IDLE;   // Next kind or wait
            end else begin
                // Rotate keeps the token even if a bit goes astray
                phase_q.ph <= {phase_q.ph[PH_W-2:0], phase_q.ph[PH_W-1]};
            end
        end
    end

    // Request captured on the start edge
    always_ff @(posedge emuclk) begin
        if (start) begin
            cyc_req_q <= i_req;
        end
    end

    // Exactly one phase bit set
    a_ph_onehot: assert property (@(posedge emuclk) disable iff (!mrst_n)
        $onehot(phase_q.ph));

endmodule

`default_nettype wire

// ==== hw/address_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module address_unit #(
    parameter logic [15:0] RESET_PC = 16'h0000
) (
    input  wire               emuclk,
    input  wire               mrst_n,

    // Command stream in
    input  wire               i_cmd_valid,
    input  wire biu_pkg::bus_cmd_t i_cmd,
    output logic              o_cmd_ready,

    // Resolved request out to the timing generator
    output logic              o_req_valid,
    output biu_pkg::bus_req_t o_req,
    input  wire               i_req_ready
);

    import biu_pkg::*;

    logic [15:0] pc_q;          // Program counter
    logic        req_valid_q;
    bus_req_t    req_q;         // Single request slot
    logic [15:0] fetch_addr;
    logic        cmd_take;
    logic        is_fetch;

    //////////////////////////////
    // Handshake
    //////////////////////////////

    // Room when empty or when the slot drains this cycle
    assign o_cmd_ready = !req_valid_q || i_req_ready;
    assign cmd_take    = i_cmd_valid && o_cmd_ready;
    assign is_fetch    = i_cmd.kind == RD4;

    assign o_req_valid = req_valid_q;
    assign o_req       = req_q;

    // Jump target replaces PC before the fetch
    assign fetch_addr = i_cmd.load_pc ? i_cmd.addr : pc_q;

    //////////////////////////////
    // Program counter
    //////////////////////////////

    always_ff @(posedge emuclk) begin
        if (!mrst_n) begin
            pc_q <= RESET_PC;
        end else if (cmd_take && is_fetch) begin
            pc_q <= fetch_addr + 16'd1;         // Wraps FFFF -> 0000
        end
    end

    //////////////////////////////
    // Request slot
    //////////////////////////////

    always_ff @(posedge emuclk) begin
        if (!mrst_n) begin
            req_valid_q <= 1'b0;
        end else if (cmd_take) begin
            req_valid_q <= 1'b1;                // Refill, possibly same edge as drain
        end else if (i_req_ready) begin
            req_valid_q <= 1'b0;
        end
    end

    always_ff @(posedge emuclk) begin
        if (cmd_take) begin
            req_q.kind  <= i_cmd.kind;
            req_q.addr  <= is_fetch ? fetch_addr : i_cmd.addr;   // RD3/WR3 use MA
            req_q.wdata <= i_cmd.wdata;
        end
    end

    // Commands must name a real bus cycle
    a_cmd_kind_legal: assert property (@(posedge emuclk) disable iff (!mrst_n)
        i_cmd_valid |-> i_cmd.kind != IDLE);

endmodule

`default_nettype wire

// ==== hw/biu_pkg.sv ====
`default_nettype none

package biu_pkg;

    //////////////////////////////
    // Bus access kinds
    //////////////////////////////

    typedef enum logic [1:0] {
        IDLE = 2'b00,   // No bus cycle
        RD4  = 2'b01,   // Opcode fetch, four states
        RD3  = 2'b10,   // Data read, three states
        WR3  = 2'b11    // Data write, three states
    } bus_acc_e;

    //////////////////////////////
    // Phase numbers
    //////////////////////////////

    localparam int PH_W             = 12;   // One-hot phase register width
    localparam int PH_ALE_OFF       = 1;    // ALE drops entering this phase
    localparam int PH_STROBE_ON     = 2;    // /RD or /WR asserted, data on port D
    localparam int PH_SAMPLE        = 6;    // Input latch at end of this phase
    localparam int PH_RD3_END       = 8;    // Last phase of RD3/WR3
    localparam int PH_RD4_END       = 11;   // Last phase of RD4
    localparam int RD4_STROBE_END   = 8;    // /RD released entering this phase
    localparam int SHORT_STROBE_END = 6;    // Same for RD3 and WR3

    //////////////////////////////
    // Payload structs
    //////////////////////////////

    // Command as it arrives from outside
    typedef struct packed {
        bus_acc_e    kind;      // IDLE not allowed
        logic        load_pc;   // RD4 only, jump first
        logic [15:0] addr;
        logic [7:0]  wdata;
    } bus_cmd_t;

    // Command with its bus address settled
    typedef struct packed {
        bus_acc_e    kind;
        logic [15:0] addr;
        logic [7:0]  wdata;
    } bus_req_t;

    // Timing generator state
    typedef struct packed {
        logic [PH_W-1:0] ph;    // One-hot
        bus_acc_e        cur;   // Kind of the running cycle
    } phase_t;

    // One per command, in order
    typedef struct packed {
        bus_acc_e    kind;
        logic [15:0] addr;      // Address put on the bus
        logic [7:0]  data;      // Read byte, or written byte for WR3
    } bus_rsp_t;

endpackage

`default_nettype wire
